//--- logic/storePkg.sv
package storePkg;

    typedef logic [31:0] Addr;      // Byte address
    typedef logic [31:0] Word;      // Store data and register values
    typedef logic [3:0]  LaneMask;  // One bit per byte lane
    typedef logic [6:0]  SqNum;     // Program-order sequence number
    typedef logic [6:0]  Tag;       // Destination tag for completion
    typedef logic [11:0] Imm;       // Raw store immediate
    typedef logic [1:0]  ModeVec;   // Core mode bits

    // Immediate forms first, then register-indirect, then cache blocks
    typedef enum logic [3:0] {
        OpSbImm,
        OpShImm,
        OpSwImm,
        OpSbReg,
        OpShReg,
        OpSwReg,
        OpCboClean,
        OpCboInval,
        OpCboFlush
    } StoreOp;

    typedef enum logic [1:0] {
        FlagsNone,
        FlagsExcept,
        FlagsOrdering
    } ResFlags;

    localparam int ModeNoCregsWr = 0;  // Block writes to the creg page
    localparam int ModeWmask     = 1;  // Enforce the 64 MB region mask

    localparam logic [7:0] CregPage = 8'hFF;  // Address bits 31:24

    // True when a is later in program order than b, wraparound safe
    function automatic logic isYounger(SqNum a, SqNum b);
        SqNum diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

//--- logic/storeUopIf.sv
`timescale 1ns/1ps

interface storeUopIf;
    import storePkg::*;

    logic   valid;   // Micro-op accepted this cycle
    StoreOp op;
    Word    srcA;    // Address base
    Word    srcB;    // Store data
    Imm     imm;
    SqNum   sqN;
    Tag     tagDst;

    modport ctrl (
        output valid,
        output op,
        output srcA,
        output srcB,
        output imm,
        output sqN,
        output tagDst
    );

    modport agu (
        input valid,
        input op,
        input srcA,
        input srcB,
        input imm,
        input sqN,
        input tagDst
    );

endinterface

//--- logic/storeIssueCtrl.sv
`timescale 1ns/1ps

module storeIssueCtrl #(
    parameter int QueueDepth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic              stall,
    input  logic              uopValid,
    input  storePkg::StoreOp  uopOp,
    input  storePkg::Word     uopSrcA,
    input  storePkg::Word     uopSrcB,
    input  storePkg::Imm      uopImm,
    input  storePkg::SqNum    uopSqN,
    input  storePkg::Tag      uopTagDst,
    input  logic              branchTaken,
    input  storePkg::SqNum    branchSqN,
    input  logic              full,
    input  storePkg::SqNum    heldSqN,
    input  logic              heldValid,
    storeUopIf.ctrl           uop,
    output logic              aguHold,
    output logic              aguKill
);
    import storePkg::*;

    logic newSquashed;   // Incoming op is on the wrong path
    logic heldSquashed;  // Op sitting in the AGU register is on the wrong path

    // Queue pointers wrap by bit slicing, so the depth has to be a power of two
    if (QueueDepth < 2 || (QueueDepth & (QueueDepth - 1)) != 0) begin : gDepthCheck
        $error("storeIssueCtrl: QueueDepth must be a power of two");
    end

    assign newSquashed  = branchTaken && isYounger(uopSqN, branchSqN);
    assign heldSquashed = heldValid && branchTaken && isYounger(heldSqN, branchSqN);

    // Core stall and a full queue both freeze the AGU output register
    assign aguHold = stall || full;
    assign aguKill = heldSquashed;

    // Single place where acceptance is decided
    assign uop.valid  = en && uopValid && !aguHold && !newSquashed;
    assign uop.op     = uopOp;
    assign uop.srcA   = uopSrcA;
    assign uop.srcB   = uopSrcB;
    assign uop.imm    = uopImm;
    assign uop.sqN    = uopSqN;
    assign uop.tagDst = uopTagDst;

endmodule

//--- logic/storeAgu.sv
`timescale 1ns/1ps

module storeAgu (
    input  logic              clk,
    input  logic              rst,
    storeUopIf.agu            uop,
    input  storePkg::ModeVec  mode,
    input  logic [63:0]       wmask64,
    input  logic              aguHold,
    input  logic              aguKill,
    output logic              resValid,
    output storePkg::Tag      resTag,
    output storePkg::ResFlags resFlags,
    output storePkg::Word     resResult,
    output logic              qValid,
    output logic              qExcept,
    output storePkg::Addr     qAddr,
    output storePkg::Word     qData,
    output storePkg::LaneMask qMask,
    output storePkg::SqNum    qSqN
);
    import storePkg::*;

    Addr     addrSum;
    Addr     effAddr;
    logic    isRegForm;
    logic    except;
    Word     alignedData;
    LaneMask laneMask;
    ResFlags nextFlags;

    assign addrSum   = uop.srcA + {{20{uop.imm[11]}}, uop.imm};
    assign isRegForm = uop.op inside {OpSbReg, OpShReg, OpSwReg,
                                      OpCboClean, OpCboInval, OpCboFlush};
    assign effAddr   = isRegForm ? uop.srcA : addrSum;  // Base only for indirect forms

    always_comb begin
        case (uop.op)
            OpSbImm, OpSbReg: except = (effAddr == '0);
            OpShImm, OpShReg: except = (effAddr == '0) || effAddr[0];
            OpSwImm, OpSwReg: except = (effAddr == '0) || (effAddr[1:0] != 2'b00);
            default:          except = 1'b0;  // Cache blocks have no alignment rule
        endcase
        if (effAddr[31:24] == CregPage && mode[ModeNoCregsWr]) begin
            except = 1'b1;
        end
        if (!wmask64[effAddr[31:26]] && mode[ModeWmask]) begin
            except = 1'b1;  // 64 MB region not writable
        end
    end

    // Byte lane steering
    always_comb begin
        laneMask    = 4'b0000;
        alignedData = uop.srcB;
        case (uop.op)
            OpSbImm, OpSbReg: begin
                laneMask    = 4'b0001 << effAddr[1:0];
                alignedData = uop.srcB << {effAddr[1:0], 3'b000};
            end
            OpShImm, OpShReg: begin
                laneMask    = effAddr[1] ? 4'b1100 : 4'b0011;
                alignedData = effAddr[1] ? (uop.srcB << 16) : uop.srcB;
            end
            OpSwImm, OpSwReg: laneMask = 4'b1111;
            OpCboClean: alignedData = 32'd0;  // Block op code in low data bits
            OpCboInval: alignedData = 32'd1;
            OpCboFlush: alignedData = 32'd2;
            default: laneMask = 4'b0000;
        endcase
    end

    always_comb begin
        if (except) begin
            nextFlags = FlagsExcept;
        end else if (uop.op == OpCboInval || uop.op == OpCboFlush) begin
            nextFlags = FlagsOrdering;
        end else begin
            nextFlags = FlagsNone;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (uop.valid) begin
            resTag    <= uop.tagDst;
            resFlags  <= nextFlags;
            resResult <= addrSum;
            qExcept   <= except;
            qAddr     <= effAddr;
            qData     <= alignedData;
            qMask     <= laneMask;
            qSqN      <= uop.sqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            qValid   <= 1'b0;
        end else begin
            resValid <= uop.valid;  // One-cycle completion, never stalled
            if (uop.valid) begin
                qValid <= 1'b1;
            end else if (!aguHold || aguKill) begin
                qValid <= 1'b0;
            end
        end
    end

endmodule

//--- logic/storeQueue.sv
`timescale 1ns/1ps

module storeQueue #(
    parameter int QueueDepth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              qValid,
    input  logic              qExcept,
    input  storePkg::Addr     qAddr,
    input  storePkg::Word     qData,
    input  storePkg::LaneMask qMask,
    input  storePkg::SqNum    qSqN,
    input  logic              aguHold,
    input  logic              commitValid,
    input  storePkg::SqNum    commitSqN,
    input  logic              branchTaken,
    input  storePkg::SqNum    branchSqN,
    output logic              full,
    output logic              memValid,
    output storePkg::Addr     memAddr,
    output storePkg::Word     memData,
    output storePkg::LaneMask memMask
);
    import storePkg::*;

    localparam int IdxW = $clog2(QueueDepth);
    localparam int PtrW = IdxW + 1;  // Extra wrap bit

    typedef logic [PtrW-1:0] Ptr;

    Addr     entAddr [QueueDepth];
    Word     entData [QueueDepth];
    LaneMask entMask [QueueDepth];
    SqNum    entSqN  [QueueDepth];

    Ptr   head;        // Oldest entry, committed or not
    Ptr   commitPtr;   // First uncommitted entry
    Ptr   tail;        // Next free slot
    Ptr   pendCnt;
    Ptr   commitAdv;
    Ptr   newCommit;
    Ptr   livePend;
    Ptr   keepCnt;
    Ptr   newTail;
    SqNum commitMark;  // Latest committed sequence number
    logic markValid;
    logic effValid;
    SqNum effSqN;
    logic enq;
    logic drain;

    assign full     = (tail - head) == Ptr'(QueueDepth);
    assign drain    = head != commitPtr;
    assign effValid = commitValid || markValid;
    assign effSqN   = commitValid ? commitSqN : commitMark;
    assign enq      = qValid && !aguHold && !qExcept
                      && !(branchTaken && isYounger(qSqN, branchSqN));

    // Commit covers a prefix of the uncommitted entries; the mark also
    // picks up stores that entered after their commit pulse
    always_comb begin
        Ptr   idx;
        logic stop;
        commitAdv = '0;
        stop      = 1'b0;
        pendCnt   = tail - commitPtr;
        for (int i = 0; i < QueueDepth; i++) begin
            idx = commitPtr + Ptr'(i);
            if (Ptr'(i) < pendCnt && !stop) begin
                if (effValid && !isYounger(entSqN[idx[IdxW-1:0]], effSqN)) begin
                    commitAdv = commitAdv + 1'b1;
                end else begin
                    stop = 1'b1;
                end
            end
        end
        newCommit = commitPtr + commitAdv;
    end

    // Branch truncation, compares all live uncommitted slots at once
    always_comb begin
        Ptr   idx;
        logic stop;
        keepCnt  = '0;
        stop     = 1'b0;
        livePend = tail - newCommit;
        for (int i = 0; i < QueueDepth; i++) begin
            idx = newCommit + Ptr'(i);
            if (Ptr'(i) < livePend && !stop) begin
                if (!isYounger(entSqN[idx[IdxW-1:0]], branchSqN)) begin
                    keepCnt = keepCnt + 1'b1;
                end else begin
                    stop = 1'b1;  // Everything after is younger too
                end
            end
        end
        newTail = branchTaken ? newCommit + keepCnt : tail;
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entAddr[newTail[IdxW-1:0]] <= qAddr;
            entData[newTail[IdxW-1:0]] <= qData;
            entMask[newTail[IdxW-1:0]] <= qMask;
            entSqN[newTail[IdxW-1:0]]  <= qSqN;
        end
        if (drain) begin
            memAddr <= entAddr[head[IdxW-1:0]];
            memData <= entData[head[IdxW-1:0]];
            memMask <= entMask[head[IdxW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            commitPtr <= '0;
            tail      <= '0;
            markValid <= 1'b0;
            memValid  <= 1'b0;
        end else begin
            memValid  <= drain;  // One committed head per cycle
            if (drain) begin
                head <= head + 1'b1;
            end
            commitPtr <= newCommit;
            tail      <= newTail + Ptr'(enq);
            if (commitValid) begin
                markValid  <= 1'b1;
                commitMark <= commitSqN;
            end
        end
    end

endmodule

//--- logic/storeUnit.sv
`timescale 1ns/1ps

module storeUnit #(
    parameter int QueueDepth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,
    input  logic              stall,
    input  storePkg::ModeVec  mode,
    input  logic [63:0]       wmask64,
    input  logic              uopValid,
    input  storePkg::StoreOp  uopOp,
    input  storePkg::Word     uopSrcA,
    input  storePkg::Word     uopSrcB,
    input  storePkg::Imm      uopImm,
    input  storePkg::SqNum    uopSqN,
    input  storePkg::Tag      uopTagDst,
    input  logic              branchTaken,
    input  storePkg::SqNum    branchSqN,
    input  logic              commitValid,
    input  storePkg::SqNum    commitSqN,
    output logic              resValid,
    output storePkg::Tag      resTag,
    output storePkg::ResFlags resFlags,
    output storePkg::Word     resResult,
    output logic              memValid,
    output storePkg::Addr     memAddr,
    output storePkg::Word     memData,
    output storePkg::LaneMask memMask
);
    import storePkg::*;

    logic    full;
    logic    aguHold;
    logic    aguKill;
    logic    qValid;
    logic    qExcept;
    Addr     qAddr;
    Word     qData;
    LaneMask qMask;
    SqNum    qSqN;

    storeUopIf uopBus ();

    storeIssueCtrl #(.QueueDepth(QueueDepth)) ctrl (
        .clk(clk), .rst(rst), .en(en), .stall(stall),
        .uopValid(uopValid), .uopOp(uopOp), .uopSrcA(uopSrcA), .uopSrcB(uopSrcB),
        .uopImm(uopImm), .uopSqN(uopSqN), .uopTagDst(uopTagDst),
        .branchTaken(branchTaken), .branchSqN(branchSqN), .full(full),
        .heldSqN(qSqN), .heldValid(qValid),  // AGU register age for squash
        .uop(uopBus), .aguHold(aguHold), .aguKill(aguKill)
    );

    storeAgu agu (
        .clk(clk), .rst(rst), .uop(uopBus), .mode(mode), .wmask64(wmask64),
        .aguHold(aguHold), .aguKill(aguKill),
        .resValid(resValid), .resTag(resTag), .resFlags(resFlags), .resResult(resResult),
        .qValid(qValid), .qExcept(qExcept), .qAddr(qAddr), .qData(qData),
        .qMask(qMask), .qSqN(qSqN)
    );

    storeQueue #(.QueueDepth(QueueDepth)) queue (
        .clk(clk), .rst(rst), .qValid(qValid), .qExcept(qExcept), .qAddr(qAddr),
        .qData(qData), .qMask(qMask), .qSqN(qSqN), .aguHold(aguHold),
        .commitValid(commitValid), .commitSqN(commitSqN),
        .branchTaken(branchTaken), .branchSqN(branchSqN), .full(full),
        .memValid(memValid), .memAddr(memAddr), .memData(memData), .memMask(memMask)
    );

endmodule

//--- tb/storeUnit_chk.sv
`timescale 1ns/1ps

module storeUnitChk (
    input logic                clk,
    input logic                rst,
    input logic                accepted,
    input logic                resValid,
    input logic                qValid,
    input logic                full,
    input logic                memValid,
    input storePkg::Addr       memAddr,
    input storePkg::LaneMask   memMask,
    input storePkg::ModeVec    mode,
    input logic [63:0]         wmask64
);
    import storePkg::*;

    logic maskLegal;

    always_comb begin
        case (memMask)
            4'b0000: maskLegal = 1'b1;  // Cache block ops
            4'b1111: maskLegal = (memAddr[1:0] == 2'd0);
            4'b0011: maskLegal = (memAddr[1:0] == 2'd0);
            4'b1100: maskLegal = (memAddr[1:0] == 2'd2);
            4'b0001, 4'b0010, 4'b0100, 4'b1000: begin
                maskLegal = (memMask == (4'b0001 << memAddr[1:0]));
            end
            default: maskLegal = 1'b0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) accepted |=> resValid)
        else $error("Completion missing one cycle after an accepted micro-op");
    assert property (@(posedge clk) disable iff (rst) resValid |-> $past(accepted))
        else $error("Completion without an accepted micro-op");
    assert property (@(posedge clk) disable iff (rst)
        memValid && mode[ModeNoCregsWr] |-> memAddr[31:24] != CregPage)
        else $error("Store to the control-register page reached memory");
    assert property (@(posedge clk) disable iff (rst) memValid |-> maskLegal)
        else $error("Illegal lane mask for the memory address");
    assert property (@(posedge clk) disable iff (rst)
        memValid && memMask != 4'b0000 |-> memAddr != '0)
        else $error("Null address store reached memory");
    assert property (@(posedge clk) disable iff (rst)
        memValid && mode[ModeWmask] |-> wmask64[memAddr[31:26]])
        else $error("Store to a write-masked region reached memory");
    assert property (@(posedge clk) rst |=> !resValid && !qValid && !memValid && !full)
        else $error("Valid or full output set right after reset");

endmodule

//--- tb/storeUnitTb.sv
`timescale 1ns/1ps

module storeUnitTb;
    import storePkg::*;

    logic clk = 1'b0;
    logic rst, en, stall, uopValid, branchTaken, commitValid;
    ModeVec mode;
    logic [63:0] wmask64;
    StoreOp uopOp;
    Word uopSrcA, uopSrcB, resResult, memData;
    Imm uopImm;
    SqNum uopSqN, branchSqN, commitSqN, sqCnt, keepSqN;
    Tag uopTagDst, resTag;
    logic resValid, memValid;
    ResFlags resFlags;
    Addr memAddr;
    LaneMask memMask;
    Addr expAddr[$];
    Word expData[$];
    LaneMask expMask[$];
    int errors = 0;
    int timeouts = 0;
    logic [31:0] lcgState = 32'd65;
    logic randStall = 1'b0;

    storeUnit #(.QueueDepth(8)) UUT (.*);

    bind storeUnit storeUnitChk chk (
        .clk(clk), .rst(rst), .accepted(uopBus.valid), .resValid(resValid),
        .qValid(qValid), .full(full),
        .memValid(memValid), .memAddr(memAddr), .memMask(memMask),
        .mode(mode), .wmask64(wmask64)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[30:15]};
    endfunction

    // Lane steering and exception rules of the store path
    function automatic void expectFor(input StoreOp op, input Addr a, input Word d,
                                      output logic exc, output LaneMask m, output Word w);
        exc = 1'b0;
        m = 4'b0000;
        w = d;
        case (op)
            OpSbImm, OpSbReg: begin
                exc = (a == '0);
                m = 4'b0001 << a[1:0];
                w = d << (8 * a[1:0]);
            end
            OpShImm, OpShReg: begin
                exc = (a == '0) || a[0];
                m = a[1] ? 4'b1100 : 4'b0011;
                w = a[1] ? (d << 16) : d;
            end
            OpSwImm, OpSwReg: begin
                exc = (a == '0) || (a[1:0] != 2'b00);
                m = 4'b1111;
            end
            OpCboClean: w = 32'd0;
            OpCboInval: w = 32'd1;
            default:    w = 32'd2;  // Flush
        endcase
        if (mode[ModeNoCregsWr] && a[31:24] == 8'hFF) exc = 1'b1;
        if (mode[ModeWmask] && !wmask64[a[31:26]]) exc = 1'b1;
    endfunction

    task automatic issue(input StoreOp op, input Word a, input Word d, input Imm imm,
                         input logic expWrite);
        Addr ea;
        Word sum;
        logic exc;
        LaneMask m;
        Word w;
        ResFlags fl;
        Tag tag;
        int t;
        @(posedge clk);
        sum = a + {{20{imm[11]}}, imm};
        ea = (op inside {OpSbImm, OpShImm, OpSwImm}) ? sum : a;
        expectFor(op, ea, d, exc, m, w);
        fl = exc ? FlagsExcept
                 : ((op == OpCboInval || op == OpCboFlush) ? FlagsOrdering : FlagsNone);
        sqCnt = sqCnt + 1'b1;
        tag = sqCnt ^ 7'h55;
        uopValid <= 1'b1;
        uopOp <= op;
        uopSrcA <= a;
        uopSrcB <= d;
        uopImm <= imm;
        uopSqN <= sqCnt;
        uopTagDst <= tag;
        t = 0;
        @(negedge clk);
        while (!UUT.uopBus.valid && t < 200) begin  // Held off by stall or full
            @(negedge clk);
            t++;
        end
        @(posedge clk);
        uopValid <= 1'b0;
        if (t >= 200) begin
            timeouts++;
            $display("Timeout: store with sequence number %0d was never accepted", sqCnt);
        end else begin
            @(negedge clk);
            assert (resValid && resFlags == fl && resResult == sum && resTag == tag) else begin
                errors++;
                $display("FAILED at %0t: completion of sqN %0d flags %0d result %h", $time,
                         sqCnt, resFlags, resResult);
            end
            if (!exc && expWrite) begin
                expAddr.push_back(ea);
                expData.push_back(w);
                expMask.push_back(m);
            end
        end
    endtask

    task automatic commit();
        @(posedge clk);
        commitValid <= 1'b1;
        commitSqN <= sqCnt;
        @(posedge clk);
        commitValid <= 1'b0;
    endtask

    task automatic waitDrain();
        int t;
        t = 0;
        while (expAddr.size() != 0 && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (expAddr.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d expected memory writes never arrived", expAddr.size());
        end
    endtask

    always @(posedge clk) stall <= randStall && (lcg() % 4 == 0);

    // Memory port against the model queue
    always @(negedge clk) begin
        if (!rst && memValid) begin
            if (expAddr.size() == 0) begin
                errors++;
                $display("Unexpected memory write to %h at %0t", memAddr, $time);
            end else begin
                assert (memAddr == expAddr[0] && memData == expData[0] && memMask == expMask[0])
                else begin
                    errors++;
                    $display("FAILED at %0t: write %h %h %b, expected %h %h %b", $time,
                             memAddr, memData, memMask, expAddr[0], expData[0], expMask[0]);
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                void'(expMask.pop_front());
            end
        end
    end

    initial begin
        rst = 1'b1;
        en = 1'b1;
        stall = 1'b0;
        mode = 2'b00;
        wmask64 = ~(64'd1 << 5);  // Region 5 not writable
        uopValid = 1'b0;
        uopOp = OpSwImm;
        uopSrcA = '0;
        uopSrcB = '0;
        uopImm = '0;
        uopSqN = '0;
        uopTagDst = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        commitValid = 1'b0;
        commitSqN = '0;
        sqCnt = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        for (int i = 0; i < 4; i++) begin
            issue(OpSbImm, 32'h1000, 32'hA5 + i, Imm'(i), 1'b1);
        end
        issue(OpShReg, 32'h2000, 32'h1234, '0, 1'b1);
        issue(OpShReg, 32'h2002, 32'h5678, '0, 1'b1);
        issue(OpSwImm, 32'h3000, 32'hDEADBEEF, 12'hFFC, 1'b1);
        repeat (10) @(posedge clk);
        assert (expAddr.size() == 7) else begin
            errors++;
            $display("FAILED at %0t: stores drained before commit", $time);
        end
        commit();
        waitDrain();

        @(posedge clk);
        mode <= 2'b11;
        issue(OpSbReg, 32'h0, 32'h11, '0, 1'b1);
        issue(OpShReg, 32'h1001, 32'h22, '0, 1'b1);
        issue(OpSwReg, 32'h1002, 32'h33, '0, 1'b1);
        issue(OpSwReg, 32'hFF000010, 32'h44, '0, 1'b1);
        issue(OpSwReg, 32'h14000000, 32'h55, '0, 1'b1);
        commit();
        repeat (10) @(posedge clk);
        mode <= 2'b00;
        issue(OpSwReg, 32'hFF000010, 32'h44, '0, 1'b1);
        issue(OpSwReg, 32'h14000000, 32'h55, '0, 1'b1);
        issue(OpCboClean, 32'h4000, 32'h0, '0, 1'b1);
        issue(OpCboInval, 32'h4000, 32'h0, '0, 1'b1);
        issue(OpCboFlush, 32'h4000, 32'h0, '0, 1'b1);
        commit();
        waitDrain();

        // Branch squash of a queued store, of the AGU register and of an incoming op
        issue(OpSwReg, 32'h5000, 32'hA, '0, 1'b1);
        commit();
        issue(OpSwReg, 32'h5004, 32'hB, '0, 1'b1);
        keepSqN = sqCnt;
        issue(OpSwReg, 32'h5008, 32'hC, '0, 1'b0);
        repeat (4) @(posedge clk);
        uopValid <= 1'b1;  // Reaches the AGU register before the branch
        uopSqN <= sqCnt + 1'b1;
        @(posedge clk);
        branchTaken <= 1'b1;
        branchSqN <= keepSqN;
        uopSqN <= sqCnt + 2'd2;
        @(negedge clk);
        assert (!UUT.uopBus.valid) else begin
            errors++;
            $display("FAILED at %0t: younger micro-op accepted during branch", $time);
        end
        @(posedge clk);
        branchTaken <= 1'b0;
        uopValid <= 1'b0;
        issue(OpSwReg, 32'h500C, 32'hE, '0, 1'b1);
        commit();
        waitDrain();

        for (int i = 0; i < 8; i++) begin
            issue(OpSwReg, 32'h6000 + 4 * i, 32'h600 + i, '0, 1'b1);
        end
        repeat (3) @(posedge clk);
        uopValid <= 1'b1;
        uopSqN <= sqCnt + 1'b1;
        repeat (5) begin
            @(negedge clk);
            assert (UUT.full && !UUT.uopBus.valid) else begin
                errors++;
                $display("FAILED at %0t: queue not full or store accepted while full", $time);
            end
        end
        @(posedge clk);
        uopValid <= 1'b0;
        commit();
        waitDrain();

        randStall <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            case (lcg() % 3)
                0: issue(OpSbReg, 32'h8000 + 4 * (lcg() % 64) + lcg() % 4,
                         lcg(), '0, 1'b1);
                1: issue(OpShReg, 32'h8000 + 4 * (lcg() % 64) + 2 * (lcg() % 2),
                         lcg(), '0, 1'b1);
                default: issue(OpSwReg, 32'h8000 + 4 * (lcg() % 64), lcg(), '0, 1'b1);
            endcase
            if (i % 5 == 4) commit();
        end
        commit();
        waitDrain();
        randStall <= 1'b0;
        repeat (5) @(posedge clk);

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/storePkg.sv
logic/storeUopIf.sv
logic/storeIssueCtrl.sv
logic/storeAgu.sv
logic/storeQueue.sv
logic/storeUnit.sv
tb/storeUnit_chk.sv
tb/storeUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module storeUnitTb -f filelist.f -o simv
out="$(./obj_dir/simv)"
echo "$out"
if grep -q "TEST RESULT: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
